//--- design/imem_axi_slave.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_axi_slave (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic [7:0]               arlen,
    output logic                     rvalid,
    input  logic                     rready,
    output imem_pkg::imem_word_t     rdata,
    output logic                     rlast,
    output imem_pkg::axi_resp_t      rresp,
    output logic                     fetch,
    output imem_pkg::word_index_t    fetch_word,
    input  logic                     line_valid,
    input  imem_pkg::imem_line_t     line_data
);

    localparam int LANE_W = $clog2(`IMEM_LANES);
    localparam int WORD_W = $bits(imem_pkg::imem_word_t);
    localparam int IDX_W  = $bits(imem_pkg::word_index_t);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT_LINE,
        ST_SEND,
        ST_DONE
    } state_t;

    state_t                state;
    state_t                state_nxt;
    logic [7:0]            len_q;
    logic [7:0]            beat;
    imem_pkg::imem_line_t  line_buf;
    logic                  ar_hs;
    logic                  r_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (ar_hs) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: begin
                state_nxt = ST_WAIT_LINE;
            end
            ST_WAIT_LINE: begin
                if (line_valid) begin
                    state_nxt = ST_SEND;
                end
            end
            ST_SEND: begin
                if (r_hs && rlast) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_q <= '0;
            beat  <= '0;
        end else if (ar_hs) begin
            len_q <= arlen;
            beat  <= '0;
        end else if (r_hs) begin
            beat <= beat + 8'd1;
        end
    end

    // start word index, address bits above the byte offset
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            fetch_word <= araddr[IDX_W+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT_LINE && line_valid) begin
            line_buf <= line_data;
        end
    end

    assign arready = (state == ST_IDLE);
    assign fetch   = (state == ST_FETCH);
    assign rvalid  = (state == ST_SEND);
    assign rlast   = rvalid && (beat == len_q);
    assign rresp   = imem_pkg::OKAY;

    // beats past one line carry zero
    assign rdata = (beat >= 8'(`IMEM_LANES)) ? '0
                 : line_buf[beat[LANE_W-1:0]*WORD_W +: WORD_W];

    a_r_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast)
    );

endmodule

//--- design/imem_bank.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_bank #(
    parameter int LANE = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rd_en,
    input  imem_pkg::word_index_t  rd_base,
    output logic                   lane_valid,
    output imem_pkg::imem_word_t   lane_word
);

    localparam int LANE_W = $clog2(`IMEM_LANES);
    localparam int IDX_W  = $bits(imem_pkg::word_index_t);
    localparam int ROWS   = `IMEM_DEPTH / `IMEM_LANES;

    imem_pkg::imem_word_t   mem [ROWS];
    logic [LANE_W-1:0]      lane_off;
    imem_pkg::word_index_t  lane_idx;
    logic [IDX_W-LANE_W-1:0] row;

    // word n holds n
    initial begin
        for (int r = 0; r < ROWS; r++) begin
            mem[r] = imem_pkg::imem_word_t'(r * `IMEM_LANES + LANE);
        end
    end

    // distance from the base to the word that lands on this lane
    assign lane_off = LANE_W'(LANE) - rd_base[LANE_W-1:0];
    assign lane_idx = rd_base + IDX_W'(lane_off);
    assign row      = lane_idx[IDX_W-1:LANE_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            lane_word <= mem[row];
        end
    end

endmodule

//--- design/imem_cfg.svh
`ifndef IMEM_CFG_SVH
`define IMEM_CFG_SVH

// memory size in 32-bit words
`define IMEM_DEPTH 8192

// banks, also words per cache line
`define IMEM_LANES 8

// array access latency in cycles
`define IMEM_LATENCY 10

// AXI byte address width
`define AXI_ADDR_W 32

`endif

//--- design/imem_fetch_dispatch.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_fetch_dispatch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch,
    input  imem_pkg::word_index_t  fetch_word,
    output logic                   rd_en,
    output imem_pkg::word_index_t  rd_base
);

    localparam int CNT_W = $clog2(`IMEM_LATENCY + 1);

    logic [CNT_W-1:0] count;
    logic             busy;

    assign busy = (count != '0);

    // loaded with latency-1 on fetch and counted down to zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (fetch) begin
            count <= CNT_W'(`IMEM_LATENCY - 1);
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    // rd_en fires on the step that reaches zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= (count == CNT_W'(1));
        end
    end

    // collector reads the base until the next fetch
    always_ff @(posedge clk) begin
        if (fetch) begin
            rd_base <= fetch_word;
        end
    end

    a_no_fetch_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch |-> !busy
    );

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch |-> ##(`IMEM_LATENCY) rd_en
    );

endmodule

//--- design/imem_line_collect.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_line_collect (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`IMEM_LANES-1:0] lane_valid,
    input  imem_pkg::imem_word_t   lane_word [`IMEM_LANES],
    input  imem_pkg::word_index_t  rd_base,
    output logic                   line_valid,
    output imem_pkg::imem_line_t   line_data
);

    localparam int LANE_W = $clog2(`IMEM_LANES);
    localparam int WORD_W = $bits(imem_pkg::imem_word_t);

    imem_pkg::imem_line_t rot_line;
    logic                 all_valid;

    assign all_valid = &lane_valid;

    // burst word i comes from lane (base + i) mod lanes
    always_comb begin
        rot_line = '0;
        for (int i = 0; i < `IMEM_LANES; i++) begin
            rot_line[i*WORD_W +: WORD_W] = lane_word[LANE_W'(i) + rd_base[LANE_W-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= all_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (all_valid) begin
            line_data <= rot_line;
        end
    end

    // banks share one strobe, so they answer together
    a_lanes_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (lane_valid == '0) || all_valid
    );

endmodule

//--- design/imem_pkg.sv
`include "imem_cfg.svh"

package imem_pkg;

    typedef logic [31:0] imem_word_t;

    // word 0 of the burst sits in the low bits
    typedef logic [`IMEM_LANES*32-1:0] imem_line_t;

    // wraps at the memory depth by width alone
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] word_index_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

endpackage

//--- design/imem_top.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic [7:0]               arlen,
    output logic                     rvalid,
    input  logic                     rready,
    output imem_pkg::imem_word_t     rdata,
    output logic                     rlast,
    output imem_pkg::axi_resp_t      rresp
);

    logic                   fetch;
    imem_pkg::word_index_t  fetch_word;
    logic                   rd_en;
    imem_pkg::word_index_t  rd_base;
    logic [`IMEM_LANES-1:0] lane_valid;
    imem_pkg::imem_word_t   lane_word [`IMEM_LANES];
    logic                   line_valid;
    imem_pkg::imem_line_t   line_data;

    imem_axi_slave u_axi_slave (
        .clk        (clk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .arlen      (arlen),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rresp      (rresp),
        .fetch      (fetch),
        .fetch_word (fetch_word),
        .line_valid (line_valid),
        .line_data  (line_data)
    );

    imem_fetch_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .fetch_word (fetch_word),
        .rd_en      (rd_en),
        .rd_base    (rd_base)
    );

    // one bank per lane, word index mod lanes picks the bank
    for (genvar k = 0; k < `IMEM_LANES; k++) begin : g_bank
        imem_bank #(
            .LANE (k)
        ) u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .rd_en      (rd_en),
            .rd_base    (rd_base),
            .lane_valid (lane_valid[k]),
            .lane_word  (lane_word[k])
        );
    end

    imem_line_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_valid (lane_valid),
        .lane_word  (lane_word),
        .rd_base    (rd_base),
        .line_valid (line_valid),
        .line_data  (line_data)
    );

endmodule

//--- dv/imem_vectors.svh
`ifndef IMEM_VECTORS_SVH
`define IMEM_VECTORS_SVH

// columns: araddr, arlen, random rready stalls, expected first word, expected beats
typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic        stall;
    logic [12:0] first;
    logic [8:0]  beats;
} burst_vec_t;

localparam int NUM_VECS = 11;

localparam burst_vec_t VECS [NUM_VECS] = '{
    '{32'h0000_0000, 8'd7,  1'b0, 13'd0,    9'd8},
    '{32'h0000_0100, 8'd7,  1'b0, 13'd64,   9'd8},
    '{32'h0000_0014, 8'd7,  1'b0, 13'd5,    9'd8},
    '{32'h0000_7ff4, 8'd7,  1'b0, 13'd8189, 9'd8},
    '{32'h0000_0040, 8'd0,  1'b0, 13'd16,   9'd1},
    '{32'h0000_001c, 8'd3,  1'b0, 13'd7,    9'd4},
    '{32'h0000_0208, 8'd11, 1'b0, 13'd130,  9'd12},
    '{32'h0001_0010, 8'd7,  1'b0, 13'd4,    9'd8},
    '{32'h0000_3000, 8'd7,  1'b1, 13'd3072, 9'd8},
    '{32'h0000_7fe4, 8'd11, 1'b1, 13'd8185, 9'd12},
    '{32'h0000_002c, 8'd2,  1'b1, 13'd11,   9'd3}
};

string vec_names [NUM_VECS] = '{
    "aligned_line",
    "aligned_mid",
    "unaligned_14",
    "wrap_top",
    "single_beat",
    "four_beats",
    "long_zero_tail",
    "high_addr_alias",
    "stall_aligned",
    "stall_wrap_long",
    "stall_short"
};

`endif

//--- dv/imem_tb.sv
`timescale 1ns/100ps
`include "imem_cfg.svh"

module imem_tb;

    localparam int AR_TIMEOUT   = 50;
    localparam int BEAT_TIMEOUT = 400;
    localparam int FIRST_DELAY  = `IMEM_LATENCY + 4;

    logic                  clk;
    logic                  rst_n;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           araddr;
    logic [7:0]            arlen;
    logic                  rvalid;
    logic                  rready;
    imem_pkg::imem_word_t  rdata;
    logic                  rlast;
    imem_pkg::axi_resp_t   rresp;

    logic [31:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          test_pass;
    int          test_fail;
    int          start_errors;
    bit          timed_out;

    `include "imem_vectors.svh"

    imem_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast),
        .rresp   (rresp)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function logic random_bit();
        random_bit = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endfunction

    task automatic compare(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            test_pass++;
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // counts falling edges until arready is seen high
    task automatic wait_arready(input string name, output int cycles);
        cycles = 0;
        while (!timed_out) begin
            @(negedge clk);
            cycles++;
            if (arready === 1'b1) begin
                break;
            end
            if (cycles >= AR_TIMEOUT) begin
                $display("timeout: arready stayed low for %0d cycles in %s", cycles, name);
                error_count++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_burst(input int idx);
        burst_vec_t  v;
        string       name;
        int          cycles;
        int          beat;
        int          first_seen;
        logic        done;
        logic        held;
        logic [31:0] held_data;
        logic [31:0] exp_data;
        v = VECS[idx];
        name = vec_names[idx];
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= v.addr;
        arlen   <= v.len;
        wait_arready(name, cycles);
        if (timed_out) begin
            return;
        end
        // AR handshake on this edge
        @(posedge clk);
        arvalid <= 1'b0;
        rready  <= v.stall ? random_bit() : 1'b1;
        beat = 0;
        cycles = 0;
        first_seen = 0;
        done = 1'b0;
        held = 1'b0;
        held_data = '0;
        while (!done && !timed_out) begin
            @(negedge clk);
            cycles++;
            compare(name, "arready in burst", 32'd0, 32'(arready));
            if (held) begin
                compare(name, "held rdata", held_data, rdata);
            end
            if (rvalid && first_seen == 0) begin
                first_seen = cycles;
                compare(name, "first rvalid delay", 32'(FIRST_DELAY), 32'(cycles));
            end
            if (rvalid && rready) begin
                exp_data = (beat < `IMEM_LANES) ?
                           32'((int'(v.first) + beat) % `IMEM_DEPTH) : 32'd0;
                compare(name, $sformatf("beat %0d rdata", beat), exp_data, rdata);
                compare(name, $sformatf("beat %0d rresp", beat), 32'd0, 32'(rresp));
                compare(name, $sformatf("beat %0d rlast", beat),
                        32'(beat == int'(v.beats) - 1), 32'(rlast));
                beat++;
                if (rlast) begin
                    done = 1'b1;
                end
            end
            held = rvalid && !rready;
            held_data = rdata;
            @(posedge clk);
            rready <= (!done && v.stall) ? random_bit() : !done;
            if (!done && cycles >= BEAT_TIMEOUT) begin
                $display("timeout: burst %s did not end within %0d cycles", name, cycles);
                error_count++;
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            return;
        end
        compare(name, "beat count", 32'(v.beats), 32'(beat));
        // one idle cycle after rlast, arready on the next
        wait_arready(name, cycles);
        if (!timed_out) begin
            compare(name, "arready gap", 32'd2, 32'(cycles));
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        arlen = '0;
        rready = 1'b0;
        lfsr_state = 32'h3bebdc29;
        error_count = 0;
        check_count = 0;
        test_pass = 0;
        test_fail = 0;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        start_errors = error_count;
        compare("reset_state", "arready", 32'd1, 32'(arready));
        compare("reset_state", "rvalid", 32'd0, 32'(rvalid));
        compare("reset_state", "rlast", 32'd0, 32'(rlast));
        report_test("reset_state", start_errors);
        for (int i = 0; i < NUM_VECS && !timed_out; i++) begin
            start_errors = error_count;
            run_burst(i);
            report_test(vec_names[i], start_errors);
        end
        $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 test_pass + test_fail, test_pass, test_fail, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+design
+incdir+dv
design/imem_pkg.sv
design/imem_axi_slave.sv
design/imem_fetch_dispatch.sv
design/imem_bank.sv
design/imem_line_collect.sv
design/imem_top.sv
dv/imem_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the instruction memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module imem_tb \
    --Mdir "$BUILD_DIR" \
    -f list.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vimem_tb" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$SIM_LOG"; then
    exit 0
else
    echo "pass message not found in $SIM_LOG"
    exit 1
fi
